// ==== flash_stimulus.txt ====
# op addr data ret expect, all hex
# op 1 mem read, 2 mem write, 3 cfg write, 4 cfg read, 5 mem read with cfg write
1 000010 00000000 DEADBEEF DEADBEEF
1 3FFFFF 00000000 12345678 12345678
1 000000 00000000 80000001 80000001
2 000020 CAFEF00D 00000000 00000000
3 000000 00000100 00000000 00000000
3 000000 0000009A 0000005E 00000000
4 000000 00000000 00000000 0000015E
1 000004 00000000 FFFFFFFF 0000015E
2 000008 11111111 00000000 00000000
3 000000 0000003C 000000A7 00000000
4 000000 00000000 00000000 000001A7
3 000000 00000100 00000000 00000000
1 000100 00000000 0F1E2D3C 0F1E2D3C
5 000200 00000071 89ABCDEF 89ABCDEF
4 000000 00000000 00000000 000001EF
1 000300 00000000 55AA55AA 000001EF
3 000000 00000100 00000000 00000000
1 2AAAAA 00000000 A5C3E1F0 A5C3E1F0
2 000001 00000000 00000000 00000000
1 155555 00000000 00000000 00000000

// ==== sources.f ====
flash_pkg.sv
flash_req_decode.sv
flash_shifter.sv
flash_capture.sv
spi_flash_ctrl.sv
tb_spi_flash_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SPI flash controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
	--top-module tb_spi_flash_ctrl \
	-f sources.f
./obj_dir/Vtb_spi_flash_ctrl

// ==== tb_spi_flash_ctrl.sv ====
// Testbench for the SPI flash read controller
// Replays flash_stimulus.txt against a behavioral SPI flash model
`default_nettype none

module tb_spi_flash_ctrl;
	import flash_pkg::*;

	localparam int ADDR_W        = 22;
	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 10;
	localparam int CYCLES_PER_OP = 100;
	// Operation codes in the stimulus file
	localparam int OP_MEM_READ  = 1;
	localparam int OP_MEM_WRITE = 2;
	localparam int OP_CFG_WRITE = 3;
	localparam int OP_CFG_READ  = 4;
	localparam int OP_BOTH      = 5;

	logic              i_clk;
	logic              i_reset;
	logic              mem_stb;
	logic              mem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic              cfg_stb;
	logic              cfg_we;
	word_t             cfg_data;
	logic              spi_miso;
	logic              o_mem_stall;
	logic              o_mem_ack;
	logic              o_cfg_stall;
	logic              o_cfg_ack;
	word_t             o_rdata;
	logic              o_spi_cs_n;
	logic              o_spi_sck;
	logic              o_spi_mosi;

	// Stimulus columns
	logic [31:0] op_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [31:0] ret_q[$];
	logic [31:0] exp_q[$];
	bit          loaded;

	// Flash model state
	word_t       model_ret;
	int          model_len;
	int          burst_idx;
	int          sck_total;
	logic [63:0] mosi_log;

	spi_flash_ctrl #(
		.ADDR_W(ADDR_W)
	) UUT (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_mem_stb   (mem_stb),
		.i_mem_we    (mem_we),
		.i_mem_addr  (mem_addr),
		.o_mem_stall (o_mem_stall),
		.o_mem_ack   (o_mem_ack),
		.i_cfg_stb   (cfg_stb),
		.i_cfg_we    (cfg_we),
		.i_cfg_data  (cfg_data),
		.o_cfg_stall (o_cfg_stall),
		.o_cfg_ack   (o_cfg_ack),
		.o_rdata     (o_rdata),
		.o_spi_cs_n  (o_spi_cs_n),
		.o_spi_sck   (o_spi_sck),
		.o_spi_mosi  (o_spi_mosi),
		.i_spi_miso  (spi_miso)
	);

	initial
	begin
		i_clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////
	// Behavioral SPI flash
	////////////////////////////////////////////////////////////

	// Records MOSI on each clocked bit, answers on the next cycle
	always @(posedge i_clk)
	begin
		int pos;
		pos = model_len - 1 - burst_idx;
		if (o_spi_sck)
		begin
			mosi_log  <= {mosi_log[62:0], o_spi_mosi};
			// Return word sits in the last 32 bits of the burst
			spi_miso  <= (pos >= 0 && pos < 32) ? model_ret[pos[4:0]] : 1'b0;
			burst_idx <= burst_idx + 1;
			sck_total <= sck_total + 1;
		end
		else
		begin
			spi_miso  <= 1'b0;
			burst_idx <= 0;
		end
	end

	////////////////////////////////////////////////////////////
	// Check helpers
	////////////////////////////////////////////////////////////

	task automatic check(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERR @%0t: %s got %h expected %h", $time, what, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// Sampled on the falling edge, away from the DUT updates
	// Counts the cycles from the accepting edge up to the ack
	task automatic wait_ack(input bit cfg, output int cycles);
		cycles = 0;
		do
		begin
			@(negedge i_clk);
			cycles = cycles + 1;
		end
		while (!(cfg ? o_cfg_ack : o_mem_ack));
	endtask

	task automatic load_stimulus();
		int    fd;
		int    cnt;
		string line;
		logic [31:0] f[5];
		fd = $fopen("flash_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file flash_stimulus.txt");
			$display("RESULT: FAIL");
			$fatal(1);
		end
		while (!$feof(fd))
		begin
			cnt = $fgets(line, fd);
			if (cnt > 0 && line[0] != "#")
			begin
				cnt = $sscanf(line, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
				if (cnt == 5)
				begin
					op_q.push_back(f[0]);
					addr_q.push_back(f[1]);
					data_q.push_back(f[2]);
					ret_q.push_back(f[3]);
					exp_q.push_back(f[4]);
				end
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus replay
	////////////////////////////////////////////////////////////

	initial
	begin
		int          sck_before;
		int          ack_cycles;
		bit          user;
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] ret;
		logic [31:0] expv;
		i_reset   = 1'b1;
		mem_stb   = 1'b0;
		mem_we    = 1'b0;
		mem_addr  = '0;
		cfg_stb   = 1'b0;
		cfg_we    = 1'b0;
		cfg_data  = '0;
		spi_miso  = 1'b0;
		model_ret = '0;
		model_len = 64;
		burst_idx = 0;
		sck_total = 0;
		mosi_log  = '0;
		user      = 1'b0;
		load_stimulus();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge i_clk);
		i_reset <= 1'b0;
		@(negedge i_clk);
		check("cs_n after reset", 32'(o_spi_cs_n), 32'd1);
		check("sck after reset", 32'(o_spi_sck), 32'd0);
		check("acks after reset", 32'({o_mem_ack, o_cfg_ack}), 32'd0);
		check("stalls after reset", 32'({o_mem_stall, o_cfg_stall}), 32'd0);

		for (int i = 0; i < op_q.size(); i++)
		begin
			op   = op_q[i];
			addr = addr_q[i];
			data = data_q[i];
			ret  = ret_q[i];
			expv = exp_q[i];
			sck_before = sck_total;
			model_ret  = ret;
			model_len  = 64;
			@(posedge i_clk);
			if (op == OP_MEM_READ || op == OP_MEM_WRITE || op == OP_BOTH)
			begin
				mem_stb  <= 1'b1;
				mem_we   <= (op == OP_MEM_WRITE);
				mem_addr <= addr[ADDR_W-1:0];
			end
			if (op == OP_CFG_WRITE || op == OP_CFG_READ || op == OP_BOTH)
			begin
				cfg_stb  <= 1'b1;
				cfg_we   <= (op != OP_CFG_READ);
				cfg_data <= data;
			end
			// Strobes drop on the edge that accepts them
			do
				@(negedge i_clk);
			while (mem_stb ? o_mem_stall : o_cfg_stall);
			if (!mem_stb)
				model_len = (op == OP_CFG_WRITE && !data[CFG_HOLD_BIT]) ? 8 : 64;
			@(posedge i_clk);
			if (mem_stb)
				mem_stb <= 1'b0;
			else
				cfg_stb <= 1'b0;

			if (op == OP_MEM_READ || op == OP_BOTH)
			begin
				// Both ports wait out the whole read
				ack_cycles = 0;
				do
				begin
					@(negedge i_clk);
					ack_cycles = ack_cycles + 1;
					if (!o_mem_ack)
						check("stalls during read", 32'({o_mem_stall, o_cfg_stall}), 32'd3);
					if (op == OP_BOTH)
						check("cfg ack during read", 32'(o_cfg_ack), 32'd0);
				end
				while (!o_mem_ack);
				check("mem ack latency", 32'(ack_cycles), user ? 32'd1 : 32'd66);
				check("mem read data", o_rdata, expv);
				check("sck pulses", 32'(sck_total - sck_before), user ? 32'd0 : 32'd64);
				if (!user)
					check("command and address", mosi_log[63:32],
						{8'h03, addr[ADDR_W-1:0], 2'b00});
				check("cs_n after read", 32'(o_spi_cs_n), user ? 32'd0 : 32'd1);
			end
			else if (op == OP_MEM_WRITE)
			begin
				wait_ack(1'b0, ack_cycles);
				check("mem write ack latency", 32'(ack_cycles), 32'd1);
				check("sck pulses on write", 32'(sck_total - sck_before), 32'd0);
			end

			if (op == OP_BOTH)
			begin
				// Control request goes out once the read has ended
				model_len  = 8;
				sck_before = sck_total;
				@(posedge i_clk);
				cfg_stb <= 1'b0;
			end
			if (op == OP_CFG_WRITE || op == OP_BOTH)
			begin
				wait_ack(1'b1, ack_cycles);
				user = !data[CFG_HOLD_BIT];
				check("cfg ack latency", 32'(ack_cycles), user ? 32'd10 : 32'd1);
				check("sck pulses on cfg", 32'(sck_total - sck_before), user ? 32'd8 : 32'd0);
				if (user)
					check("sent byte", 32'(mosi_log[7:0]), 32'(data[7:0]));
				check("cs_n after cfg", 32'(o_spi_cs_n), user ? 32'd0 : 32'd1);
			end
			else if (op == OP_CFG_READ)
			begin
				wait_ack(1'b1, ack_cycles);
				check("cfg read ack latency", 32'(ack_cycles), 32'd1);
				check("cfg read data", o_rdata, expv);
			end
		end
		$display("RESULT: PASS");
		$finish;
	end

	// Run time bound from the number of operations
	initial
	begin
		wait (loaded);
		#((op_q.size() * CYCLES_PER_OP + RESET_CYCLES) * CLK_PERIOD);
		$display("Timeout: the testbench did not finish the stimulus in time");
		$display("RESULT: FAIL");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== spi_flash_ctrl.sv ====
// Low logic SPI flash read controller, top level
// Memory port reads the flash with 03h, control port sends raw bytes
`default_nettype none

module spi_flash_ctrl #(
	parameter int ADDR_W = 22
) (
	input  logic              i_clk,
	input  logic              i_reset,
	// Memory port
	input  logic              i_mem_stb,
	input  logic              i_mem_we,
	input  logic [ADDR_W-1:0] i_mem_addr,
	output logic              o_mem_stall,
	output logic              o_mem_ack,
	// Control port
	input  logic              i_cfg_stb,
	input  logic              i_cfg_we,
	input  flash_pkg::word_t  i_cfg_data,
	output logic              o_cfg_stall,
	output logic              o_cfg_ack,
	// Shared read data
	output flash_pkg::word_t  o_rdata,
	// SPI pins
	output logic              o_spi_cs_n,
	output logic              o_spi_sck,
	output logic              o_spi_mosi,
	input  logic              i_spi_miso
);
	import flash_pkg::*;

	// Decoder outputs
	logic      start;
	xfer_req_t req;
	logic      quick;
	req_port_t quick_port;
	logic      user_mode;
	// Shifter outputs
	logic      busy;
	logic      sample;
	logic      done;
	req_port_t done_port;

	flash_req_decode #(
		.ADDR_W(ADDR_W)
	) u_decode (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_mem_stb    (i_mem_stb),
		.i_mem_we     (i_mem_we),
		.i_mem_addr   (i_mem_addr),
		.i_cfg_stb    (i_cfg_stb),
		.i_cfg_we     (i_cfg_we),
		.i_cfg_data   (i_cfg_data),
		.i_busy       (busy),
		.o_mem_stall  (o_mem_stall),
		.o_cfg_stall  (o_cfg_stall),
		.o_start      (start),
		.o_req        (req),
		.o_quick      (quick),
		.o_quick_port (quick_port),
		.o_user_mode  (user_mode)
	);

	flash_shifter u_shifter (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_start     (start),
		.i_req       (req),
		.i_user_mode (user_mode),
		.o_busy      (busy),
		.o_sample    (sample),
		.o_done      (done),
		.o_done_port (done_port),
		.o_spi_cs_n  (o_spi_cs_n),
		.o_spi_sck   (o_spi_sck),
		.o_spi_mosi  (o_spi_mosi)
	);

	flash_capture u_capture (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_spi_miso   (i_spi_miso),
		.i_sample     (sample),
		.i_done       (done),
		.i_done_port  (done_port),
		.i_quick      (quick),
		.i_quick_port (quick_port),
		.i_user_mode  (user_mode),
		.o_mem_ack    (o_mem_ack),
		.o_cfg_ack    (o_cfg_ack),
		.o_rdata      (o_rdata)
	);

endmodule

`default_nettype wire

// ==== flash_capture.sv ====
// Response capture for the SPI flash controller
// Shifts in MISO, forms the control word and raises the port acks
`default_nettype none

module flash_capture (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_spi_miso,
	// From the shifter
	input  logic                 i_sample,
	input  logic                 i_done,
	input  flash_pkg::req_port_t i_done_port,
	// From the decoder
	input  logic                 i_quick,
	input  flash_pkg::req_port_t i_quick_port,
	input  logic                 i_user_mode,
	// Bus responses
	output logic                 o_mem_ack,
	output logic                 o_cfg_ack,
	output flash_pkg::word_t     o_rdata
);
	import flash_pkg::*;

	word_t rx_word;
	word_t ctrl_word;
	logic  mem_hit;
	logic  cfg_hit;

	////////////////////////////////////////////////////////////
	// Read data
	////////////////////////////////////////////////////////////

	// MSB first, the last bit lands just before the ack
	always_ff @(posedge i_clk)
	begin
		if (i_sample)
			rx_word <= {rx_word[30:0], i_spi_miso};
	end

	// Hold bit set, received byte in the low bits
	always_comb
	begin
		ctrl_word               = '0;
		ctrl_word[CFG_HOLD_BIT] = 1'b1;
		ctrl_word[7:0]          = rx_word[7:0];
	end

	// In user mode both ports see the control word
	assign o_rdata = i_user_mode ? ctrl_word : rx_word;

	////////////////////////////////////////////////////////////
	// Acks
	////////////////////////////////////////////////////////////

	// Done and quick never coincide, only one request is in flight
	assign mem_hit = (i_done && (i_done_port == PORT_MEM))
		|| (i_quick && (i_quick_port == PORT_MEM));
	assign cfg_hit = (i_done && (i_done_port == PORT_CFG))
		|| (i_quick && (i_quick_port == PORT_CFG));

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_mem_ack <= 1'b0;
			o_cfg_ack <= 1'b0;
		end
		else
		begin
			o_mem_ack <= mem_hit;
			o_cfg_ack <= cfg_hit;
		end
	end

endmodule

`default_nettype wire

// ==== flash_shifter.sv ====
// Serial shift engine for the SPI flash controller
// Runs the bit counter, drives SCK, MOSI and chip select, marks MISO samples
`default_nettype none

module flash_shifter (
	input  logic                 i_clk,
	input  logic                 i_reset,
	// Request from the decoder
	input  logic                 i_start,
	input  flash_pkg::xfer_req_t i_req,
	input  logic                 i_user_mode,
	output logic                 o_busy,
	// Capture strobes
	output logic                 o_sample,
	output logic                 o_done,
	output flash_pkg::req_port_t o_done_port,
	// SPI pins
	output logic                 o_spi_cs_n,
	output logic                 o_spi_sck,
	output logic                 o_spi_mosi
);
	import flash_pkg::*;

	bit_count_t bit_cnt;
	word_t      tx_shift;
	req_port_t  port_q;

	////////////////////////////////////////////////////////////
	// Bit counter and serial clock
	////////////////////////////////////////////////////////////

	// Counts the clocked bits still to go
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			bit_cnt <= '0;
		else if (i_start)
			bit_cnt <= (i_req.kind == KIND_READ) ? READ_BITS : XFER_BITS;
		else if (bit_cnt != '0)
			bit_cnt <= bit_cnt - 1'b1;
	end

	// One SCK cycle per bit, the last one when the count reaches one
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_spi_sck <= 1'b0;
		else if (i_start)
			o_spi_sck <= 1'b1;
		else
			o_spi_sck <= (bit_cnt > bit_count_t'(1));
	end

	// Flash answers one cycle after each clocked bit
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_sample <= 1'b0;
		else
			o_sample <= o_spi_sck;
	end

	// Busy covers the clocked bits and the trailing sample
	assign o_busy = o_spi_sck || o_sample;
	// Last sample with the clock already stopped
	assign o_done = o_sample && !o_spi_sck;

	////////////////////////////////////////////////////////////
	// MOSI
	////////////////////////////////////////////////////////////

	// Read sends 03h and the address, a transfer sends its byte
	// Zeros backfill while the read word comes in
	always_ff @(posedge i_clk)
	begin
		if (i_start)
		begin
			if (i_req.kind == KIND_READ)
				tx_shift <= {FLASH_READ_CMD, i_req.byte_addr};
			else
				tx_shift <= {i_req.tx_byte, 24'h000000};
		end
		else if (o_spi_sck)
			tx_shift <= {tx_shift[30:0], 1'b0};
	end

	// MSB first
	assign o_spi_mosi = tx_shift[31];

	// Port that owns the ack at the end
	always_ff @(posedge i_clk)
	begin
		if (i_start)
			port_q <= i_req.port;
	end

	assign o_done_port = port_q;

	// Selected during a transfer and for as long as user mode lasts
	assign o_spi_cs_n = !(i_user_mode || o_busy);

endmodule

`default_nettype wire

// ==== flash_req_decode.sv ====
// Request decoder for the SPI flash controller
// Arbitrates the memory and control ports, keeps user mode, and issues
// serial transfers or immediate answers
`default_nettype none

module flash_req_decode #(
	parameter int ADDR_W = 22
) (
	input  logic                 i_clk,
	input  logic                 i_reset,
	// Memory port
	input  logic                 i_mem_stb,
	input  logic                 i_mem_we,
	input  logic [ADDR_W-1:0]    i_mem_addr,
	// Control port
	input  logic                 i_cfg_stb,
	input  logic                 i_cfg_we,
	input  flash_pkg::word_t     i_cfg_data,
	// Shifter status
	input  logic                 i_busy,
	output logic                 o_mem_stall,
	output logic                 o_cfg_stall,
	// Transfer request to the shifter
	output logic                 o_start,
	output flash_pkg::xfer_req_t o_req,
	// Immediate answer to the capture block
	output logic                 o_quick,
	output flash_pkg::req_port_t o_quick_port,
	output logic                 o_user_mode
);
	import flash_pkg::*;

	logic mem_accept;
	logic cfg_accept;
	logic mem_read;
	logic cfg_xfer;
	logic user_mode;

	////////////////////////////////////////////////////////////
	// Port arbitration
	////////////////////////////////////////////////////////////

	// Both ports wait while a transfer is on the wire
	assign o_mem_stall = i_busy;
	// Memory port has fixed priority over the control port
	assign o_cfg_stall = i_busy || i_mem_stb;

	// At most one of these is high in any cycle
	assign mem_accept = i_mem_stb && !o_mem_stall;
	assign cfg_accept = i_cfg_stb && !o_cfg_stall;

	// Flash is only read while chip select is ours
	assign mem_read = mem_accept && !i_mem_we && !user_mode;
	// Control write with the hold bit low clocks out one byte
	assign cfg_xfer = cfg_accept && i_cfg_we && !i_cfg_data[CFG_HOLD_BIT];

	// Anything else is answered on the next cycle
	assign o_start      = mem_read || cfg_xfer;
	assign o_quick      = (mem_accept || cfg_accept) && !o_start;
	assign o_quick_port = mem_accept ? PORT_MEM : PORT_CFG;

	////////////////////////////////////////////////////////////
	// Request record
	////////////////////////////////////////////////////////////

	always_comb
	begin
		o_req.port      = mem_accept ? PORT_MEM : PORT_CFG;
		o_req.kind      = mem_accept ? KIND_READ : KIND_XFER;
		// Word address to byte address, always aligned
		o_req.byte_addr = flash_addr_t'({i_mem_addr, 2'b00});
		o_req.tx_byte   = i_cfg_data[7:0];
		o_req.pad       = '0;
	end

	// User mode holds chip select low across control writes
	// and is left by a control write with the hold bit set
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			user_mode <= 1'b0;
		else if (cfg_accept && i_cfg_we)
			user_mode <= !i_cfg_data[CFG_HOLD_BIT];
	end

	assign o_user_mode = user_mode;

endmodule

`default_nettype wire

// ==== flash_pkg.sv ====
// Shared definitions for the SPI flash read controller
// Widths, the flash read command, serial bit counts and the request record
`default_nettype none

package flash_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// One bus data word
	typedef logic [31:0] word_t;

	// One byte on the serial line
	typedef logic [7:0] spi_byte_t;

	// Flash byte address as it goes out on MOSI
	typedef logic [23:0] flash_addr_t;

	// Serial bit counter, room for a whole read and the tail cycle
	typedef logic [6:0] bit_count_t;

	////////////////////////////////////////////////////////////
	// Flash protocol constants
	////////////////////////////////////////////////////////////

	// Plain read, no dummy cycles
	localparam spi_byte_t FLASH_READ_CMD = 8'h03;

	// Command, address and data word
	localparam bit_count_t READ_BITS = 7'd64;
	// One raw byte through the control port
	localparam bit_count_t XFER_BITS = 7'd8;

	// Control word bit that releases chip select and ends user mode
	localparam int CFG_HOLD_BIT = 8;

	////////////////////////////////////////////////////////////
	// Request record
	////////////////////////////////////////////////////////////

	// Which bus port issued a request
	typedef enum logic {
		PORT_MEM = 1'b0,
		PORT_CFG = 1'b1
	} req_port_t;

	// Flash word read or raw control byte
	typedef enum logic {
		KIND_READ = 1'b0,
		KIND_XFER = 1'b1
	} req_kind_t;

	// One serial transfer handed from the decoder to the shifter
	typedef struct packed {
		req_port_t   port;
		req_kind_t   kind;
		flash_addr_t byte_addr;
		spi_byte_t   tx_byte;
		// Rounds the record up to whole bytes
		logic [5:0]  pad;
	} xfer_req_t;

endpackage

`default_nettype wire
